//--- singleCpu.f
hw/cpuPkg.sv
hw/pcUnit.sv
hw/instMem.sv
hw/regFile.sv
hw/decoder.sv
hw/alu.sv
hw/dataMem.sv
hw/singleCpu.sv
bench/singleCpu_chk.sv
bench/singleCpuTb.sv

//--- Bender.yml
package:
  name: singleCpu

sources:
  - hw/cpuPkg.sv
  - hw/pcUnit.sv
  - hw/instMem.sv
  - hw/regFile.sv
  - hw/decoder.sv
  - hw/alu.sv
  - hw/dataMem.sv
  - hw/singleCpu.sv
  - target: simulation
    files:
      - bench/singleCpu_chk.sv
      - bench/singleCpuTb.sv

//--- bench/singleCpuTb.sv
module singleCpuTb;
    import cpuPkg::*;

    // One cycle of expected observation port values
    typedef struct packed {
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     instr;
        logic                wbEn;
        logic [regAddrW-1:0] wbAddr;
        logic [xlen-1:0]     wbData;
    } expT;

    logic                 CLK;
    logic                 rstN;
    logic                 loadEn;
    logic [imemAddrW-1:0] loadAddr;
    logic [xlen-1:0]      loadData;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      instr;
    logic                 wbEn;
    logic [regAddrW-1:0]  wbAddr;
    logic [xlen-1:0]      wbData;

    logic [xlen-1:0] prog [imemWords];  // Program image
    string           tags [imemWords];  // Test name per word
    int              progLen;
    logic [xlen-1:0] haltPc;

    // ISA model state
    logic [xlen-1:0] mPc;
    logic [xlen-1:0] mRegs [32];
    logic [xlen-1:0] mMem [dmemWords];

    logic [31:0] lcgState;
    int          mismatchCount;
    int          otherCount;
    logic        done;

    // R-type funct7 bit 30 and funct3 pairs and I-type funct3 codes
    logic [3:0] rOps [8] = '{4'b0000, 4'b1000, 4'b0111, 4'b0110,
                             4'b0100, 4'b0010, 4'b0001, 4'b0101};
    logic [2:0] iOps [5] = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};

    singleCpu u_singleCpu (
        .CLK      (CLK),
        .rstN     (rstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .pc       (pc),
        .instr    (instr),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] rFormat(input logic sub, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, opR};
    endfunction

    function automatic logic [31:0] iFormat(input logic [6:0] opc, input logic [11:0] imm,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sFormat(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    // Offset in bytes whose bit 0 the format drops
    function automatic logic [31:0] bFormat(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    // Executes one instruction on the model
    function automatic expT refStep();
        expT             e;
        logic [xlen-1:0] ins;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] immI;
        logic [xlen-1:0] immS;
        logic [xlen-1:0] immB;
        logic [xlen-1:0] res;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] nextPc;
        logic            write;
        ins    = prog[mPc[9:2]];
        a      = mRegs[ins[19:15]];
        b      = mRegs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        res    = '0;
        write  = 1'b0;
        nextPc = mPc + 32'd4;
        case (ins[6:0])
            opR: begin
                res   = aluRef(ins[14:12], ins[30], a, b);
                write = 1'b1;
            end
            opI: begin
                res   = aluRef(ins[14:12], 1'b0, a, immI);
                write = 1'b1;
            end
            opLoad: begin
                addr  = a + immI;
                res   = mMem[addr[9:2]];
                write = 1'b1;
            end
            opStore: begin
                addr             = a + immS;
                mMem[addr[9:2]] = b;
            end
            opBranch: begin
                if (ins[12] ? (a != b) : (a == b)) begin  // bne on funct3 001
                    nextPc = mPc + immB;
                end
            end
            default: ;
        endcase
        e.pc     = mPc;
        e.instr  = ins;
        e.wbEn   = write && (ins[11:7] != 5'd0);
        e.wbAddr = ins[11:7];
        e.wbData = res;
        if (e.wbEn) begin
            mRegs[ins[11:7]] = res;
        end
        mPc = nextPc;
        return e;
    endfunction

    task automatic emit(input string t, input logic [31:0] w);
        prog[progLen] = w;
        tags[progLen] = t;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] fields;
        int          kind;
        progLen  = 0;
        lcgState = 32'd7872;
        emit("alu", iFormat(opI, 12'd5, 5'd0, 3'b000, 5'd1));      // addi x1, x0, 5
        emit("alu", iFormat(opI, 12'hFFD, 5'd0, 3'b000, 5'd2));    // addi x2, x0, -3
        emit("alu", rFormat(1'b0, 5'd2, 5'd1, 3'b000, 5'd3));
        emit("alu", rFormat(1'b1, 5'd2, 5'd1, 3'b000, 5'd4));      // sub
        emit("alu", rFormat(1'b0, 5'd2, 5'd1, 3'b111, 5'd5));
        emit("alu", rFormat(1'b0, 5'd2, 5'd1, 3'b110, 5'd6));
        emit("alu", rFormat(1'b0, 5'd2, 5'd1, 3'b100, 5'd7));
        emit("alu", rFormat(1'b0, 5'd1, 5'd2, 3'b010, 5'd8));      // slt gives one
        emit("alu", rFormat(1'b0, 5'd2, 5'd1, 3'b010, 5'd9));      // slt gives zero
        emit("alu", rFormat(1'b0, 5'd1, 5'd1, 3'b001, 5'd10));
        emit("alu", rFormat(1'b0, 5'd1, 5'd2, 3'b101, 5'd11));     // srl of a negative
        emit("alu", iFormat(opI, 12'h0F0, 5'd2, 3'b111, 5'd12));
        emit("alu", iFormat(opI, 12'hF00, 5'd1, 3'b110, 5'd13));
        emit("alu", iFormat(opI, 12'hFFF, 5'd2, 3'b100, 5'd14));
        emit("alu", iFormat(opI, 12'hFFE, 5'd2, 3'b010, 5'd15));   // slti -3 < -2
        // Writes to x0 must not stick
        emit("x0", iFormat(opI, 12'd7, 5'd1, 3'b000, 5'd0));
        emit("x0", rFormat(1'b0, 5'd1, 5'd0, 3'b000, 5'd3));
        emit("x0", rFormat(1'b0, 5'd2, 5'd1, 3'b100, 5'd0));
        emit("x0", rFormat(1'b0, 5'd0, 5'd0, 3'b000, 5'd6));
        emit("mem", iFormat(opI, 12'd64, 5'd0, 3'b000, 5'd9));     // Base address
        emit("mem", sFormat(12'd0, 5'd4, 5'd9));
        emit("mem", sFormat(12'd4, 5'd7, 5'd9));
        emit("mem", sFormat(12'hFF8, 5'd2, 5'd9));
        emit("mem", iFormat(opLoad, 12'd0, 5'd9, 3'b010, 5'd10));
        emit("mem", iFormat(opLoad, 12'd4, 5'd9, 3'b010, 5'd11));
        emit("mem", iFormat(opLoad, 12'hFF8, 5'd9, 3'b010, 5'd12));
        emit("mem", sFormat(12'd0, 5'd1, 5'd9));                   // Overwrite
        emit("mem", iFormat(opLoad, 12'd0, 5'd9, 3'b010, 5'd13));
        emit("branch", bFormat(13'd8, 5'd2, 5'd1, 3'b000));        // beq not taken
        emit("branch", bFormat(13'd8, 5'd2, 5'd1, 3'b001));        // bne taken
        emit("branch", iFormat(opI, 12'd99, 5'd0, 3'b000, 5'd13));
        emit("branch", bFormat(13'd8, 5'd3, 5'd1, 3'b000));        // beq taken
        emit("branch", iFormat(opI, 12'd99, 5'd0, 3'b000, 5'd14));
        emit("branch", bFormat(13'd8, 5'd3, 5'd1, 3'b001));        // bne not taken
        emit("branch", iFormat(opI, 12'd3, 5'd0, 3'b000, 5'd5));
        emit("branch", iFormat(opI, 12'hFFF, 5'd5, 3'b000, 5'd5));
        emit("branch", bFormat(13'h1FFC, 5'd0, 5'd5, 3'b001));     // Loop back 3 times
        for (int i = 0; i < 40; i++) begin
            lcgState = lcgNext(lcgState);
            kind     = int'(lcgState[31:16] % 16'd13);
            lcgState = lcgNext(lcgState);
            fields   = lcgState;
            if (kind < 8) begin
                emit("random", rFormat(rOps[kind][3], {1'b0, fields[23:20]},
                                       {1'b0, fields[27:24]}, rOps[kind][2:0],
                                       {1'b0, fields[31:28]}));
            end else begin
                emit("random", iFormat(opI, fields[19:8], {1'b0, fields[27:24]},
                                       iOps[kind-8], {1'b0, fields[31:28]}));
            end
        end
        haltPc = xlen'(progLen * 4);
        emit("halt", bFormat(13'd0, 5'd0, 5'd0, 3'b000));          // Self loop
        mPc = '0;
        for (int r = 0; r < 32; r++) begin
            mRegs[r] = '0;
        end
    endtask

    task automatic compareWord(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            mismatchCount++;
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic printCounts();
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 mismatchCount, otherCount, u_singleCpu.u_chk.assertFails);
    endtask

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        rstN          = 1'b0;
        loadEn        = 1'b0;
        loadAddr      = '0;
        loadData      = '0;
        mismatchCount = 0;
        otherCount    = 0;
        done          = 1'b0;
        buildProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge CLK);
            loadEn   <= 1'b1;
            loadAddr <= imemAddrW'(i);
            loadData <= prog[i];
        end
        @(posedge CLK);
        loadEn <= 1'b0;
        repeat (3) @(posedge CLK);  // Reset outlasts the load
        rstN <= 1'b1;
    end

    initial begin : compareLoop
        expT   e;
        string t;
        int    tail;
        tail = 0;
        wait (rstN === 1'b1);
        @(negedge CLK);
        // Idle cycle between release and the first instruction
        compareWord("reset pc", '0, pc);
        compareWord("reset wbEn", '0, xlen'(wbEn));
        compareWord("reset instr", '0, instr);
        while (tail < 4) begin
            @(negedge CLK);
            e = refStep();
            t = tags[e.pc[9:2]];
            compareWord({t, " pc"}, e.pc, pc);
            compareWord({t, " instr"}, e.instr, instr);
            compareWord({t, " wbEn"}, xlen'(e.wbEn), xlen'(wbEn));
            if (e.wbEn) begin
                compareWord({t, " wbAddr"}, xlen'(e.wbAddr), xlen'(wbAddr));
                compareWord({t, " wbData"}, e.wbData, wbData);
            end
            if (e.pc == haltPc) begin
                tail++;
            end
        end
        done = 1'b1;
    end

    initial begin
        wait (done === 1'b1);
        @(negedge CLK);
        printCounts();
        if (mismatchCount == 0 && otherCount == 0 && u_singleCpu.u_chk.assertFails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (rstN === 1'b1);
        #((progLen + 50) * 4);
        otherCount++;
        $display("Timeout: the core did not reach its halt loop within %0d cycles",
                 progLen + 50);
        printCounts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- bench/singleCpu_chk.sv
module singleCpu_chk (
    input logic                        CLK,
    input logic                        rstN,
    input logic                        running,
    input logic [cpuPkg::xlen-1:0]     pc,
    input logic                        wbEn,
    input logic [cpuPkg::regAddrW-1:0] wbAddr
);

    int assertFails = 0;  // Failure tally, read by the testbench

    pcHeldInReset: assert property (@(posedge CLK) !rstN |-> pc == '0)
        else begin
            assertFails++;
            $error("pc left zero while reset was asserted");
        end

    // No write to x0 and none before the core runs
    noIdleWrite: assert property (@(posedge CLK) disable iff (!rstN)
        (wbAddr == '0 || !running) |-> !wbEn)
        else begin
            assertFails++;
            $error("write-back enabled for x0 or while not running");
        end

    pcAligned: assert property (@(posedge CLK) pc[1:0] == 2'b00)
        else begin
            assertFails++;
            $error("pc is not word aligned");
        end

endmodule

bind singleCpu singleCpu_chk u_chk (
    .CLK     (CLK),
    .rstN    (rstN),
    .running (running),
    .pc      (pc),
    .wbEn    (wbEn),
    .wbAddr  (wbAddr)
);

//--- hw/singleCpu.sv
module singleCpu (
    input  logic                         CLK,
    input  logic                         rstN,
    input  logic                         loadEn,
    input  logic [cpuPkg::imemAddrW-1:0] loadAddr,
    input  logic [cpuPkg::xlen-1:0]      loadData,
    output logic [cpuPkg::xlen-1:0]      pc,
    output logic [cpuPkg::xlen-1:0]      instr,
    output logic                         wbEn,
    output logic [cpuPkg::regAddrW-1:0]  wbAddr,
    output logic [cpuPkg::xlen-1:0]      wbData
);
    import cpuPkg::*;

    logic            running;
    logic [xlen-1:0] fetched;
    ctrlT            ctrl;
    decT             dec;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluY;
    logic            zero;
    logic [xlen-1:0] memRd;

    pcUnit u_pcUnit (
        .CLK      (CLK),
        .rstN     (rstN),
        .branch   (ctrl.branch),
        .branchNe (ctrl.branchNe),
        .zero     (zero),
        .imm      (dec.imm),
        .pc       (pc),
        .running  (running)
    );

    instMem u_instMem (
        .CLK      (CLK),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .pc       (pc),
        .instr    (fetched)
    );

    decoder u_decoder (
        .instr   (fetched),
        .running (running),
        .ctrl    (ctrl),
        .dec     (dec)
    );

    regFile u_regFile (
        .CLK  (CLK),
        .rstN (rstN),
        .rs1  (dec.rs1),
        .rs2  (dec.rs2),
        .rd   (wbAddr),
        .we   (wbEn),
        .wd   (wbData),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    assign aluB = ctrl.aluSrc ? dec.imm : rd2;  // Operand b select

    alu u_alu (
        .a    (rd1),
        .b    (aluB),
        .op   (ctrl.aluOp),
        .y    (aluY),
        .zero (zero)
    );

    dataMem u_dataMem (
        .CLK  (CLK),
        .we   (ctrl.memWrite),
        .addr (aluY),
        .wd   (rd2),
        .rd   (memRd)
    );

    // Write-back select and observation ports
    assign wbData = ctrl.memToReg ? memRd : aluY;
    assign wbAddr = dec.rd;
    assign wbEn   = ctrl.regWrite && (dec.rd != '0);
    // Fetch port reads zero until the core is running
    assign instr  = running ? fetched : '0;

endmodule

//--- hw/dataMem.sv
module dataMem (
    input  logic                    CLK,
    input  logic                    we,
    input  logic [cpuPkg::xlen-1:0] addr,
    input  logic [cpuPkg::xlen-1:0] wd,
    output logic [cpuPkg::xlen-1:0] rd
);
    import cpuPkg::*;

    logic [xlen-1:0]      mem [dmemWords];
    logic [dmemAddrW-1:0] wordIdx;

    // Word accesses only, low address bits ignored
    assign wordIdx = addr[dmemAddrW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wd;
        end
    end

    assign rd = mem[wordIdx];

endmodule

//--- hw/alu.sv
module alu (
    input  logic [cpuPkg::xlen-1:0] a,
    input  logic [cpuPkg::xlen-1:0] b,
    input  cpuPkg::aluOpT           op,
    output logic [cpuPkg::xlen-1:0] y,
    output logic                    zero
);
    import cpuPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            aluAdd: y = a + b;
            aluSub: y = a - b;
            aluAnd: y = a & b;
            aluOr:  y = a | b;
            aluXor: y = a ^ b;
            aluSlt: begin
                y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            aluSll: y = a << shamt;
            aluSrl: y = a >> shamt;  // Logical, no sign fill
            default: begin
                y = '0;
            end
        endcase
    end

    // Branch compare flag
    assign zero = (y == '0);

endmodule

//--- hw/decoder.sv
module decoder (
    input  logic [cpuPkg::xlen-1:0] instr,
    input  logic                    running,
    output cpuPkg::ctrlT            ctrl,
    output cpuPkg::decT             dec
);
    import cpuPkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            funct7b30;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;

    // funct3 to ALU op, sub selects subtraction on funct3 000
    function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic sub);
        aluOpT op;
        case (f3)
            3'b000:  op = sub ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b100:  op = aluXor;
            3'b101:  op = aluSrl;
            3'b110:  op = aluOr;
            3'b111:  op = aluAnd;
            default: op = aluAdd;  // sltu not in the subset
        endcase
        return op;
    endfunction

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7b30 = instr[30];

    // Immediates by format, all sign extended from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        ctrl = '0;
        if (running) begin
            case (opcode)
                opR: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = aluFromFunct(funct3, funct7b30);
                end
                opI: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.aluOp    = aluFromFunct(funct3, 1'b0);  // No subi
                end
                opLoad: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.aluOp    = aluAdd;
                end
                opStore: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = 1'b1;
                    ctrl.aluOp    = aluAdd;
                end
                opBranch: begin
                    ctrl.branch   = 1'b1;
                    ctrl.branchNe = funct3[0];  // 000 beq, 001 bne
                    ctrl.aluOp    = aluSub;
                end
                default: ctrl = '0;  // Unknown opcode acts as a no-op
            endcase
        end
    end

    always_comb begin
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd  = instr[11:7];
        case (opcode)
            opStore:  dec.imm = immS;
            opBranch: dec.imm = immB;
            default:  dec.imm = immI;
        endcase
    end

endmodule

//--- hw/regFile.sv
module regFile (
    input  logic                        CLK,
    input  logic                        rstN,
    input  logic [cpuPkg::regAddrW-1:0] rs1,
    input  logic [cpuPkg::regAddrW-1:0] rs2,
    input  logic [cpuPkg::regAddrW-1:0] rd,
    input  logic                        we,
    input  logic [cpuPkg::xlen-1:0]     wd,
    output logic [cpuPkg::xlen-1:0]     rd1,
    output logic [cpuPkg::xlen-1:0]     rd2
);
    import cpuPkg::*;

    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // x0 reads as zero whatever the array holds
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/instMem.sv
module instMem (
    input  logic                         CLK,
    input  logic                         loadEn,
    input  logic [cpuPkg::imemAddrW-1:0] loadAddr,
    input  logic [cpuPkg::xlen-1:0]      loadData,
    input  logic [cpuPkg::xlen-1:0]      pc,
    output logic [cpuPkg::xlen-1:0]      instr
);
    import cpuPkg::*;

    logic [xlen-1:0] mem [imemWords];

    // Program load port, one word per edge
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    assign instr = mem[pc[imemAddrW+1:2]];  // Byte address to word index

endmodule

//--- hw/pcUnit.sv
module pcUnit (
    input  logic                    CLK,
    input  logic                    rstN,
    input  logic                    branch,
    input  logic                    branchNe,
    input  logic                    zero,
    input  logic [cpuPkg::xlen-1:0] imm,
    output logic [cpuPkg::xlen-1:0] pc,
    output logic                    running
);
    import cpuPkg::*;

    logic [xlen-1:0] nextPc;
    logic            taken;

    // beq wants zero set, bne wants it clear
    assign taken  = branch && (zero == !branchNe);
    assign nextPc = taken ? pc + imm : pc + xlen'(4);

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc      <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            // Hold at zero for the idle cycle after release
            if (running) begin
                pc <= nextPc;
            end
        end
    end

endmodule

//--- hw/cpuPkg.sv
package cpuPkg;

    // Datapath and register index widths
    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Memory depths in words
    localparam int imemWords = 256;
    localparam int dmemWords = 256;
    localparam int imemAddrW = 8;
    localparam int dmemAddrW = 8;

    // Major opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,  // Signed compare
        aluSll = 4'd6,
        aluSrl = 4'd7
    } aluOpT;

    // Main control bundle, 10 bits
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;    // 1 selects the immediate as operand b
        logic  memWrite;
        logic  memToReg;  // 1 writes back load data
        logic  branch;
        logic  branchNe;  // Inverts the zero test
        aluOpT aluOp;
    } ctrlT;

    // Register indices and immediate, 47 bits
    typedef struct packed {
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     imm;
    } decT;

endpackage
